// ==== all.f ====
logic/hilo_pkg.sv
logic/hilo_regs.sv
logic/div_ctrl.sv
logic/div_count.sv
logic/div_datapath.sv
logic/hilo_ex_stage.sv
logic/hilo_pipe.sv
logic/hilo_top.sv
sim/hilo_tb.sv

// ==== sim/hilo_tb.sv ====
module hilo_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import hilo_pkg::*;

    localparam int rd_timeout  = 8;               // Cycles allowed for rd_valid_o
    localparam int div_timeout = 100;             // Cycles allowed for one divide

    typedef struct packed {
        logic [3:0] tid;                          // Test number
        hilo_op_e   op;
        word_t      rs;
        word_t      rt;
        word_t      exp;                          // Expected read data
    } stim_t;

    logic   clk;
    logic   rst_n_i;
    issue_t issue_i;
    logic   stall_o;
    logic   rd_valid_o;
    word_t  rd_data_o;

    stim_t       stim_q[$];                       // Stimulus table
    logic [31:0] lfsr;
    word_t       ref_hi;                          // Reference HI
    word_t       ref_lo;                          // Reference LO
    int          errors;
    int          tests_run;
    int          tests_failed;

    hilo_top u_hilo_top (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .issue_i    (issue_i),
        .stall_o    (stall_o),
        .rd_valid_o (rd_valid_o),
        .rd_data_o  (rd_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                    // 8 ns period
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_word(input int nbits, output word_t w);
        w = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);               // One step per bit
            w    = {w[word_w-2:0], lfsr[0]};
        end
    endtask

    // Append one entry and advance the HI/LO model at issue time
    task automatic add_step(input int tid, input hilo_op_e op, input word_t rs, input word_t rt);
        logic [63:0] prod;
        stim_t       s;
        prod = '0;
        s    = '{tid: tid[3:0], op: op, rs: rs, rt: rt, exp: '0};
        case (op)
            op_mult: begin
                prod   = {{32{rs[31]}}, rs} * {{32{rt[31]}}, rt};   // Low 64 bits signed
                ref_hi = prod[63:32];
                ref_lo = prod[31:0];
            end
            op_multu: begin
                prod   = {32'h0, rs} * {32'h0, rt};
                ref_hi = prod[63:32];
                ref_lo = prod[31:0];
            end
            op_divu: begin
                if (rt == '0) begin               // Zero divisor
                    ref_hi = rs;
                    ref_lo = '1;
                end else begin
                    ref_hi = rs % rt;             // Remainder to HI
                    ref_lo = rs / rt;             // Quotient to LO
                end
            end
            op_mthi: ref_hi = rs;
            op_mtlo: ref_lo = rs;
            op_mfhi: s.exp = ref_hi;
            op_mflo: s.exp = ref_lo;
            default: ;
        endcase
        stim_q.push_back(s);
    endtask

    task automatic build_table();
        word_t a;
        word_t b;
        add_step(1, op_mfhi, '0, '0);             // Reset values
        add_step(1, op_mflo, '0, '0);
        for (int gap = 0; gap < 3; gap++) begin   // MEM, WB, register path
            rand_word(32, a);
            add_step(2, op_mthi, a, '0);
            for (int k = 0; k < gap; k++) begin
                add_step(2, op_nop, '0, '0);
            end
            add_step(2, op_mfhi, '0, '0);
        end
        rand_word(32, a);
        rand_word(32, b);
        add_step(3, op_mtlo, a, '0);
        add_step(3, op_mtlo, b, '0);              // Younger write wins
        add_step(3, op_mflo, '0, '0);
        for (int k = 0; k < 4; k++) begin
            rand_word(32, a);
            rand_word(32, b);
            add_step(4, (k % 2) ? op_multu : op_mult, a, b);
            add_step(4, op_mfhi, '0, '0);
            add_step(4, op_mflo, '0, '0);
        end
        for (int k = 0; k < 4; k++) begin
            rand_word(32, a);
            rand_word((k + 1) * 8, b);            // Divisor widths 8 to 32 bits
            add_step(5, op_divu, a, b);
            add_step(5, op_mfhi, '0, '0);         // Issued in the done cycle
            add_step(5, op_mflo, '0, '0);
        end
        rand_word(32, a);
        add_step(5, op_divu, a, '0);
        add_step(5, op_mfhi, '0, '0);
        add_step(5, op_mflo, '0, '0);
    endtask

    // Issue one entry at a falling edge and check what comes back
    task automatic apply(input stim_t s);
        int   n;
        logic is_rd;
        is_rd   = (s.op == op_mfhi || s.op == op_mflo);
        issue_i = '{valid: 1'b1, op: s.op, rs: s.rs, rt: s.rt};
        @(posedge clk);                           // Accepted here
        @(negedge clk);
        if (is_rd) begin
            n = 0;
            while (rd_valid_o !== 1'b1 && n < rd_timeout) begin
                @(negedge clk);
                n++;
            end
            if (rd_valid_o !== 1'b1) begin
                $display("Read in test %0d got no rd_valid_o within %0d cycles", s.tid, n);
                errors++;
            end else if (n != 0) begin
                $display("ERROR %0t: rd_valid_o came %0d cycles late", $time, n);
                errors++;
            end else if (rd_data_o !== s.exp) begin
                $display("ERROR %0t: read of %s gave %h, expected %h", $time,
                         (s.op == op_mfhi) ? "HI" : "LO", rd_data_o, s.exp);
                errors++;
            end
        end else if (rd_valid_o !== 1'b0) begin
            $display("ERROR %0t: rd_valid_o high after a non-read op", $time);
            errors++;
        end
        if (s.op == op_divu) begin
            if (stall_o !== 1'b1) begin
                $display("ERROR %0t: stall_o not raised after divide", $time);
                errors++;
            end
            n = 0;
            while (stall_o && n < div_timeout) begin  // Issue held meanwhile
                @(negedge clk);
                n++;
            end
            if (stall_o) begin
                $display("Divide in test %0d never finished, stall_o high %0d cycles", s.tid, n);
                errors++;
            end
        end
    endtask

    function automatic string test_name(input int t);
        case (t)
            1:       return "reset values";
            2:       return "HI forwarding";
            3:       return "back-to-back LO";
            4:       return "multiply";
            5:       return "divide";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_test(input int t, input int err_at);
        tests_run++;
        if (errors > err_at) begin
            tests_failed++;
            $display("Test %0d (%s): FAIL with %0d errors", t, test_name(t), errors - err_at);
        end else begin
            $display("Test %0d (%s): ok", t, test_name(t));
        end
    endtask

    initial begin
        int cur;
        int err_at;
        issue_i      = '0;
        rst_n_i      = 1'b0;
        lfsr         = 32'hd15c;
        ref_hi       = '0;
        ref_lo       = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        build_table();
        repeat (5) @(posedge clk);                // Reset for 5 cycles
        @(negedge clk);
        rst_n_i = 1'b1;
        cur     = 1;
        err_at  = 0;
        if (stall_o !== 1'b0 || rd_valid_o !== 1'b0) begin
            $display("ERROR %0t: stall_o or rd_valid_o high after reset", $time);
            errors++;
        end
        foreach (stim_q[i]) begin
            if (stim_q[i].tid != cur) begin      // Previous test finished
                report_test(cur, err_at);
                cur    = stim_q[i].tid;
                err_at = errors;
            end
            apply(stim_q[i]);
        end
        report_test(cur, err_at);
        issue_i = '0;
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/hilo_top.sv ====
module hilo_top (
    input  logic             clk,
    input  logic             rst_n_i,
    input  hilo_pkg::issue_t issue_i,
    output logic             stall_o,
    output logic             rd_valid_o,
    output hilo_pkg::word_t  rd_data_o
);
    import hilo_pkg::*;

    hilo_wr_t ex_wr;
    hilo_wr_t mem_wr;
    hilo_wr_t wb_wr;
    word_t    hi_fwd;
    word_t    lo_fwd;
    word_t    div_q;
    word_t    div_r;
    logic     div_load;
    logic     div_step;
    logic     div_last;
    logic     div_done;

    hilo_ex_stage u_ex (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .issue_i    (issue_i),
        .stall_i    (stall_o),
        .div_done_i (div_done),
        .div_q_i    (div_q),
        .div_r_i    (div_r),
        .hi_fwd_i   (hi_fwd),
        .lo_fwd_i   (lo_fwd),
        .ex_wr_o    (ex_wr),
        .rd_valid_o (rd_valid_o),
        .rd_data_o  (rd_data_o)
    );

    div_ctrl u_div_ctrl (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .issue_i (issue_i),
        .last_i  (div_last),
        .load_o  (div_load),
        .step_o  (div_step),
        .done_o  (div_done),
        .stall_o (stall_o)
    );

    div_count u_div_count (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .load_i  (div_load),
        .step_i  (div_step),
        .last_o  (div_last)
    );

    // Operands sampled on load, rs over rt
    div_datapath u_div_dp (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .load_i     (div_load),
        .step_i     (div_step),
        .dividend_i (issue_i.rs),
        .divisor_i  (issue_i.rt),
        .quot_o     (div_q),
        .rem_o      (div_r)
    );

    hilo_pipe u_pipe (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .ex_wr_i  (ex_wr),
        .mem_wr_o (mem_wr),
        .wb_wr_o  (wb_wr)
    );

    hilo_regs u_regs (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .mem_wr_i (mem_wr),
        .wb_wr_i  (wb_wr),
        .hi_o     (hi_fwd),
        .lo_o     (lo_fwd)
    );

endmodule

// ==== logic/hilo_pipe.sv ====
module hilo_pipe (
    input  logic               clk,
    input  logic               rst_n_i,
    input  hilo_pkg::hilo_wr_t ex_wr_i,
    output hilo_pkg::hilo_wr_t mem_wr_o,
    output hilo_pkg::hilo_wr_t wb_wr_o
);
    import hilo_pkg::*;

    hilo_wr_t mem_q;                              // EX to MEM
    hilo_wr_t wb_q;                               // MEM to WB

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_q.hi_we <= 1'b0;                  // No pending write in MEM
            mem_q.lo_we <= 1'b0;
            wb_q.hi_we  <= 1'b0;
            wb_q.lo_we  <= 1'b0;
        end else begin
            mem_q <= ex_wr_i;                     // Empty entry on stall
            wb_q  <= mem_q;
        end
    end

    assign mem_wr_o = mem_q;
    assign wb_wr_o  = wb_q;

endmodule

// ==== logic/hilo_ex_stage.sv ====
module hilo_ex_stage (
    input  logic               clk,
    input  logic               rst_n_i,
    input  hilo_pkg::issue_t   issue_i,
    input  logic               stall_i,           // Divider busy
    input  logic               div_done_i,
    input  hilo_pkg::word_t    div_q_i,
    input  hilo_pkg::word_t    div_r_i,
    input  hilo_pkg::word_t    hi_fwd_i,          // Forwarded HI
    input  hilo_pkg::word_t    lo_fwd_i,          // Forwarded LO
    output hilo_pkg::hilo_wr_t ex_wr_o,
    output logic               rd_valid_o,
    output hilo_pkg::word_t    rd_data_o
);
    import hilo_pkg::*;

    logic               op_ok;                    // Accepted this cycle
    logic               sgn;
    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [65:0] prod;                     // Low 64 bits are the result
    word_t              hi_src;
    word_t              lo_src;

    assign op_ok = issue_i.valid && !stall_i;
    assign sgn   = (issue_i.op == op_mult);

    // One 33x33 signed multiplier serves both mult and multu
    assign mul_a = {sgn & issue_i.rs[word_w-1], issue_i.rs};
    assign mul_b = {sgn & issue_i.rt[word_w-1], issue_i.rt};
    assign prod  = mul_a * mul_b;

    // Divide result merges with the op issued alongside it
    always_comb begin
        ex_wr_o = '0;
        if (div_done_i) begin
            ex_wr_o = '{hi_we: 1'b1, lo_we: 1'b1, hi: div_r_i, lo: div_q_i};
        end
        if (op_ok) begin
            case (issue_i.op)
                op_mult, op_multu: begin
                    ex_wr_o = '{hi_we: 1'b1, lo_we: 1'b1,
                                hi: prod[63:32], lo: prod[31:0]};
                end
                op_mthi: begin
                    ex_wr_o.hi_we = 1'b1;
                    ex_wr_o.hi    = issue_i.rs;
                end
                op_mtlo: begin
                    ex_wr_o.lo_we = 1'b1;
                    ex_wr_o.lo    = issue_i.rs;
                end
                default: ;                        // nop, divu, reads
            endcase
        end
    end

    // Finished divide is younger than anything in MEM
    assign hi_src = div_done_i ? div_r_i : hi_fwd_i;
    assign lo_src = div_done_i ? div_q_i : lo_fwd_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= op_ok && (issue_i.op == op_mfhi || issue_i.op == op_mflo);
        end
    end

    always_ff @(posedge clk) begin
        rd_data_o <= (issue_i.op == op_mfhi) ? hi_src : lo_src;
    end

endmodule

// ==== logic/div_datapath.sv ====
module div_datapath (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            load_i,
    input  logic            step_i,
    input  hilo_pkg::word_t dividend_i,
    input  hilo_pkg::word_t divisor_i,
    output hilo_pkg::word_t quot_o,
    output hilo_pkg::word_t rem_o
);
    import hilo_pkg::*;

    word_t             rem_q;                     // Partial remainder
    word_t             quot_q;                    // Dividend bits shift out, quotient bits in
    word_t             dvsr_q;                    // Divisor held for the whole run
    logic [word_w:0]   shl;                       // Remainder with next dividend bit
    logic [word_w:0]   diff;                      // Trial subtraction

    assign shl  = {rem_q, quot_q[word_w-1]};
    assign diff = shl - {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rem_q  <= '0;
            quot_q <= '0;
        end else if (load_i) begin
            rem_q  <= '0;
            quot_q <= dividend_i;
        end else if (step_i) begin
            if (!diff[word_w]) begin              // Non-negative, keep difference
                rem_q  <= diff[word_w-1:0];
                quot_q <= {quot_q[word_w-2:0], 1'b1};
            end else begin                        // Restore
                rem_q  <= shl[word_w-1:0];
                quot_q <= {quot_q[word_w-2:0], 1'b0};
            end
        end
    end

    // Divisor register
    always_ff @(posedge clk) begin
        if (load_i) begin
            dvsr_q <= divisor_i;                  // Zero divisor gives all-ones quotient
        end
    end

    assign quot_o = quot_q;
    assign rem_o  = rem_q;

endmodule

// ==== logic/div_count.sv ====
module div_count (
    input  logic clk,
    input  logic rst_n_i,
    input  logic load_i,                          // Start of a division
    input  logic step_i,                          // One iteration taken
    output logic last_o                           // Final iteration
);
    import hilo_pkg::*;

    logic [4:0] cnt_q;                            // Steps left minus one

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= 5'(div_steps - 1);           // 31 down to 0
        end else if (step_i) begin
            cnt_q <= cnt_q - 5'd1;                // Wraps after last, unused then
        end
    end

    assign last_o = step_i && (cnt_q == 5'd0);

endmodule

// ==== logic/div_ctrl.sv ====
module div_ctrl (
    input  logic             clk,
    input  logic             rst_n_i,
    input  hilo_pkg::issue_t issue_i,
    input  logic             last_i,              // Final step this cycle
    output logic             load_o,              // Capture operands
    output logic             step_o,              // One shift-subtract
    output logic             done_o,              // Quotient and remainder ready
    output logic             stall_o              // Hold the issue port
);
    import hilo_pkg::*;

    div_state_e state_q;
    div_state_e state_d;
    logic       start;

    assign start = issue_i.valid && (issue_i.op == op_divu);

    always_comb begin
        state_d = state_q;
        load_o  = 1'b0;
        step_o  = 1'b0;
        case (state_q)
            div_idle: begin
                if (start) begin
                    load_o  = 1'b1;
                    state_d = div_run;
                end
            end
            div_run: begin
                step_o = 1'b1;                    // Step every cycle
                if (last_i) begin
                    state_d = div_done;
                end
            end
            div_done: begin
                // Issue is open again, a new divide may start at once
                if (start) begin
                    load_o  = 1'b1;
                    state_d = div_run;
                end else begin
                    state_d = div_idle;
                end
            end
            default: state_d = div_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= div_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign done_o  = (state_q == div_done);
    assign stall_o = (state_q == div_run);        // Low in done, next op proceeds

endmodule

// ==== logic/hilo_regs.sv ====
module hilo_regs (
    input  logic               clk,
    input  logic               rst_n_i,
    input  hilo_pkg::hilo_wr_t mem_wr_i,          // Youngest pending write
    input  hilo_pkg::hilo_wr_t wb_wr_i,           // Oldest pending write
    output hilo_pkg::word_t    hi_o,
    output hilo_pkg::word_t    lo_o
);
    import hilo_pkg::*;

    word_t hi_q;                                  // Architectural HI
    word_t lo_q;                                  // Architectural LO

    // Commit at end of WB
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (wb_wr_i.hi_we) begin
                hi_q <= wb_wr_i.hi;
            end
            if (wb_wr_i.lo_we) begin
                lo_q <= wb_wr_i.lo;
            end
        end
    end

    // HI read, MEM beats WB beats register
    always_comb begin
        if (mem_wr_i.hi_we) begin
            hi_o = mem_wr_i.hi;
        end else if (wb_wr_i.hi_we) begin
            hi_o = wb_wr_i.hi;                    // Written at next edge
        end else begin
            hi_o = hi_q;
        end
    end

    // LO read, same priority
    always_comb begin
        if (mem_wr_i.lo_we) begin
            lo_o = mem_wr_i.lo;
        end else if (wb_wr_i.lo_we) begin
            lo_o = wb_wr_i.lo;
        end else begin
            lo_o = lo_q;
        end
    end

endmodule

// ==== logic/hilo_pkg.sv ====
package hilo_pkg;

    localparam int word_w    = 32;               // Data path width
    localparam int div_steps = 32;               // One quotient bit per step

    typedef logic [word_w-1:0] word_t;

    // Operations accepted on the issue port
    typedef enum logic [2:0] {
        op_nop   = 3'd0,
        op_mult  = 3'd1,                          // Signed 32x32
        op_multu = 3'd2,                          // Unsigned 32x32
        op_divu  = 3'd3,                          // Unsigned, multicycle
        op_mthi  = 3'd4,
        op_mtlo  = 3'd5,
        op_mfhi  = 3'd6,
        op_mflo  = 3'd7
    } hilo_op_e;

    // Divider FSM
    typedef enum logic [1:0] {
        div_idle = 2'd0,
        div_run  = 2'd1,                          // Shift-subtract steps
        div_done = 2'd2                           // Result valid for one cycle
    } div_state_e;

    // Pending HI/LO write of one pipeline stage
    typedef struct packed {
        logic  hi_we;
        logic  lo_we;
        word_t hi;
        word_t lo;
    } hilo_wr_t;

    // One issued operation
    typedef struct packed {
        logic     valid;
        hilo_op_e op;
        word_t    rs;                             // Dividend / multiplicand / move source
        word_t    rt;                             // Divisor / multiplier
    } issue_t;

endpackage
